// ==== Makefile ====
# Verilator build for the MIDI front end testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f all.f --top-module synth_tb -Mdir $(OBJ_DIR) -o synth_sim
	@out=$$(./$(OBJ_DIR)/synth_sim); echo "$$out"; \
		echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
hw/synth_pkg.sv
hw/midi_msg_if.sv
hw/bit_timer.sv
hw/midi_rx.sv
hw/midi_parser.sv
hw/channel_state.sv
hw/synthesizer_top.sv
verification/clock_gen.sv
verification/synth_checker.sv
verification/synth_tb.sv

// ==== hw/bit_timer.sv ====
// bit timer for the serial receiver
// half-bit first tick, whole-bit ticks after that
module bit_timer #(
	parameter int clks_per_bit = synth_pkg::clks_per_bit
) (
	input  logic CLOCK_25,
	input  logic reset1,
	input  logic start,	// falling edge seen, aim at bit centre
	input  logic run,	// frame in progress
	output logic tick	// sample point
);

	localparam int cnt_w = $clog2(clks_per_bit);

	// reload values
	localparam logic [cnt_w-1:0] half_load = cnt_w'(clks_per_bit / 2 - 1);
	localparam logic [cnt_w-1:0] full_load = cnt_w'(clks_per_bit - 1);

	logic [cnt_w-1:0] count;	// cycles left to next sample

	// tick on terminal count, only inside a frame
	assign tick = run && !start && (count == '0);

	always_ff @(posedge CLOCK_25) begin
		if (!reset1) begin
			count <= '0;
		end else if (start) begin
			count <= half_load;	// first sample mid start bit
		end else if (tick) begin
			count <= full_load;	// then one per bit
		end else if (run) begin
			count <= count - 1'b1;
		end
		// idle between bytes, count just holds
	end

endmodule

// ==== hw/channel_state.sv ====
// voice table and pitch bend register
// lowest-free-slot allocation, sticky off-note error
module channel_state import synth_pkg::*; #(
	parameter int voices = default_voices
) (
	input  logic                              CLOCK_25,
	input  logic                              reset1,
	midi_msg_if.sink                          msg,
	output logic [voices-1:0]                 keys_on,	// slot busy flags
	output logic [voices*$bits(note_t)-1:0]   slot_notes,	// slot i at bits i*7
	output bend_t                             pitch_val,
	output logic                              note_error
);

	localparam int nw = $bits(note_t);

	note_t             slot_note [voices];	// note held per slot
	logic [voices-1:0] hit;	// slot already holds msg note
	logic [voices-1:0] grant;	// lowest free slot, one-hot
	logic              held, take_slot;

	////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < voices; i++)
			hit[i] = keys_on[i] && (slot_note[i] == msg.data1);
	end

	// lowest clear bit of keys_on, zero when all full
	assign grant = ~keys_on & (keys_on + 1'b1);
	assign held  = |hit;

	// new note gets a slot, full table just drops it
	assign take_slot = msg.valid && (msg.kind == msg_note_on) && !held;

	////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLOCK_25) begin
		if (!reset1) begin
			keys_on    <= '0;
			note_error <= 1'b0;
			pitch_val  <= bend_center;
		end else if (msg.valid) begin
			case (msg.kind)
				msg_note_on: begin
					if (!held)
						keys_on <= keys_on | grant;
				end
				msg_note_off: begin
					if (held)
						keys_on <= keys_on & ~hit;	// free that slot
					else
						note_error <= 1'b1;	// off for a note we never had
				end
				msg_bend: pitch_val <= {msg.data2, msg.data1};	// msb:lsb
				default: ;
			endcase
		end
	end

	// note storage
	always_ff @(posedge CLOCK_25) begin
		for (int i = 0; i < voices; i++) begin
			if (take_slot && grant[i])
				slot_note[i] <= msg.data1;
		end
	end

	// flatten for the top level ports
	for (genvar g = 0; g < voices; g++) begin : g_flat
		assign slot_notes[g*nw +: nw] = slot_note[g];
	end

endmodule

// ==== hw/midi_msg_if.sv ====
// parsed message bus, parser to voice table
// single-cycle strobe, no back-pressure
interface midi_msg_if import synth_pkg::*; ();

	logic      valid;	// one cycle per message
	msg_kind_t kind;
	logic [6:0] data1;	// note number or bend lsb
	logic [6:0] data2;	// velocity or bend msb

	// parser side
	modport source (
		output valid,
		output kind,
		output data1,
		output data2
	);

	// voice table side, must take every strobe
	modport sink (
		input valid,
		input kind,
		input data1,
		input data2
	);

endinterface

// ==== hw/midi_parser.sv ====
// MIDI channel message parser
// running status, real-time filter, channel select
module midi_parser import synth_pkg::*; (
	input  logic             CLOCK_25,
	input  logic             reset1,
	input  logic             byte_valid,
	input  midi_byte_t       rx_byte,
	input  logic [3:0]       midi_ch,	// listen channel, held steady
	midi_msg_if.source       msg
);

	typedef enum logic [1:0] {
		st_status,	// no running status, data bytes dropped
		st_data1,	// expecting first data byte
		st_data2,	// expecting second data byte
		st_ignore	// second byte of an unused message
	} state_t;

	state_t     state;
	midi_byte_t run_status;	// last channel status byte
	note_t      data1_q;	// held first data byte
	msg_kind_t  next_kind;
	logic       data_byte, status_byte, our_ch;

	// real-time bytes never reach the FSM
	assign data_byte   = byte_valid && !rx_byte[7];
	assign status_byte = byte_valid && rx_byte[7] && (rx_byte < realtime_min);
	assign our_ch      = (run_status[3:0] == midi_ch);

	// kind to emit on the second data byte
	always_comb begin
		case (run_status[7:4])
			status_note_on:  next_kind = (rx_byte[6:0] == '0) ? msg_note_off : msg_note_on;
			status_note_off: next_kind = msg_note_off;
			status_bend:     next_kind = msg_bend;
			default:         next_kind = msg_none;
		endcase
	end

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLOCK_25) begin
		if (!reset1) begin
			state      <= st_status;
			run_status <= '0;
			msg.valid  <= 1'b0;
		end else begin
			msg.valid <= data_byte && (state == st_data2);
			if (status_byte) begin
				if (rx_byte[7:4] == 4'hF) begin
					run_status <= '0;	// sysex or common, kills running status
					state      <= st_status;
				end else begin
					run_status <= rx_byte;
					state      <= st_data1;
				end
			end else if (data_byte) begin
				case (state)
					st_data1: begin
						case (run_status[7:4])
							status_note_off, status_note_on, status_bend:
								state <= our_ch ? st_data2 : st_ignore;
							status_prog, status_pressure:
								state <= st_data1;	// one data byte, consumed
							status_ctrl:
								state <= st_ignore;	// controller value follows
							default:
								state <= st_ignore;	// poly pressure
						endcase
					end
					st_data2:  state <= st_data1;	// running status, back for more
					st_ignore: state <= st_data1;
					default:   state <= st_status;	// stray data, dropped
				endcase
			end
		end
	end

	// payload, no reset needed
	always_ff @(posedge CLOCK_25) begin
		if (data_byte && state == st_data1)
			data1_q <= rx_byte[6:0];
		if (data_byte && state == st_data2) begin
			msg.kind  <= next_kind;
			msg.data1 <= data1_q;
			msg.data2 <= rx_byte[6:0];
		end
	end

endmodule

// ==== hw/midi_rx.sv ====
// MIDI serial receiver, 8N1 lsb first
// line sync, start edge detect, stop bit check
module midi_rx import synth_pkg::*; #(
	parameter int clks_per_bit = synth_pkg::clks_per_bit
) (
	input  logic       CLOCK_25,
	input  logic       reset1,
	input  logic       midi_rxd,	// idle high
	output logic       byte_valid,	// one cycle, good stop bit only
	output midi_byte_t rx_byte
);

	logic       rxd_meta, rxd_sync, rxd_prev;	// two-flop sync plus edge reg
	logic       busy;	// inside a frame
	logic [3:0] bit_idx;	// 0 start, 1..8 data, 9 stop
	logic       start, tick;
	midi_byte_t shift_reg;

	// falling edge on an idle line opens a frame
	assign start   = !busy && rxd_prev && !rxd_sync;
	assign rx_byte = shift_reg;

	bit_timer #(.clks_per_bit(clks_per_bit)) u_timer (
		.CLOCK_25 (CLOCK_25),
		.reset1   (reset1),
		.start    (start),
		.run      (busy),
		.tick     (tick)
	);

	always_ff @(posedge CLOCK_25) begin
		if (!reset1) begin
			rxd_meta   <= 1'b1;
			rxd_sync   <= 1'b1;
			rxd_prev   <= 1'b1;
			busy       <= 1'b0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
		end else begin
			rxd_meta   <= midi_rxd;
			rxd_sync   <= rxd_meta;
			rxd_prev   <= rxd_sync;
			byte_valid <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				bit_idx <= '0;
			end else if (tick) begin
				if (bit_idx == 4'd0 && rxd_sync) begin
					busy <= 1'b0;	// glitch, not a real start bit
				end else if (bit_idx == 4'd9) begin
					busy       <= 1'b0;
					byte_valid <= rxd_sync;	// framing error drops the byte
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end
		end
	end

	// data shifter, lsb arrives first
	always_ff @(posedge CLOCK_25) begin
		if (tick && bit_idx != 4'd0 && bit_idx != 4'd9)
			shift_reg <= {rxd_sync, shift_reg[7:1]};
	end

endmodule

// ==== hw/synth_pkg.sv ====
// shared constants for the MIDI front end
// status nibbles, reset values, byte and message types
package synth_pkg;

	////////////////////////////////////////////////////////////
	// timing and sizes
	////////////////////////////////////////////////////////////
	parameter int clks_per_bit   = 800;	// 25 MHz / 31250 baud
	parameter int default_voices = 2;	// two-voice synth

	// upper nibble of a channel status byte
	parameter logic [3:0] status_note_off = 4'h8;
	parameter logic [3:0] status_note_on  = 4'h9;
	parameter logic [3:0] status_ctrl     = 4'hB;
	parameter logic [3:0] status_prog     = 4'hC;
	parameter logic [3:0] status_pressure = 4'hD;	// channel pressure
	parameter logic [3:0] status_bend     = 4'hE;

	parameter logic [7:0]  realtime_min = 8'hF8;	// clock, start, stop ...
	parameter logic [13:0] bend_center  = 14'd8192;	// wheel at rest

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////
	typedef logic [7:0]  midi_byte_t;
	typedef logic [6:0]  note_t;
	typedef logic [13:0] bend_t;

	// what the parser hands to the voice table
	typedef enum logic [1:0] {
		msg_none,
		msg_note_on,
		msg_note_off,
		msg_bend
	} msg_kind_t;

endpackage

// ==== hw/synthesizer_top.sv ====
// MIDI front end top level
// receiver, parser and voice table
module synthesizer_top import synth_pkg::*; #(
	parameter int voices       = default_voices,
	parameter int clks_per_bit = synth_pkg::clks_per_bit
) (
	input  logic                            CLOCK_25,
	input  logic                            reset1,
	input  logic                            midi_rxd,	// serial in
	input  logic [3:0]                      midi_ch,	// channel select
	output logic [voices-1:0]               keys_on,
	output logic [voices*$bits(note_t)-1:0] slot_notes,
	output bend_t                           pitch_val,
	output logic                            note_error
);

	logic       byte_valid;
	midi_byte_t rx_byte;

	midi_msg_if msg_bus ();	// parser to voice table

	////////////////////////////////////////////////////////////
	// serial in, parse, voice table
	////////////////////////////////////////////////////////////
	midi_rx #(.clks_per_bit(clks_per_bit)) u_rx (
		.CLOCK_25   (CLOCK_25),
		.reset1     (reset1),
		.midi_rxd   (midi_rxd),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte)
	);

	midi_parser u_parser (
		.CLOCK_25   (CLOCK_25),
		.reset1     (reset1),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte),
		.midi_ch    (midi_ch),
		.msg        (msg_bus.source)
	);

	channel_state #(.voices(voices)) u_chan (
		.CLOCK_25   (CLOCK_25),
		.reset1     (reset1),
		.msg        (msg_bus.sink),
		.keys_on    (keys_on),
		.slot_notes (slot_notes),
		.pitch_val  (pitch_val),
		.note_error (note_error)
	);

endmodule

// ==== verification/clock_gen.sv ====
// testbench clock and reset source
// 40 ns clock, reset1 low for the first 10 cycles
module clock_gen (
	output logic CLOCK_25,
	output logic reset1
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLOCK_25 = 1'b0;
		forever #20 CLOCK_25 = ~CLOCK_25;	// 40 ns period
	end

	// synchronous reset, released just after an edge
	initial begin
		reset1 = 1'b0;
		repeat (10) @(posedge CLOCK_25);
		#1;
		reset1 = 1'b1;
	end

endmodule

// ==== verification/synth_checker.sv ====
// concurrent assertions on the voice table
// unique notes, update timing, sticky note error
module synth_checker import synth_pkg::*; #(
	parameter int voices = default_voices
) (
	input logic                            CLOCK_25,
	input logic                            reset1,
	input logic                            valid,	// parsed message strobe
	input logic [voices-1:0]               keys_on,
	input logic [voices*$bits(note_t)-1:0] slot_notes,
	input bend_t                           pitch_val,
	input logic                            note_error
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int nw = $bits(note_t);

	int unsigned fail_count = 0;	// failing property count

	// true when two busy slots carry the same note
	function automatic logic has_dup(input logic [voices-1:0] keys,
			input logic [voices*nw-1:0] notes);
		logic found;
		found = 1'b0;
		for (int i = 0; i < voices; i++)
			for (int j = i + 1; j < voices; j++)
				if (keys[i] && keys[j] && notes[i*nw +: nw] == notes[j*nw +: nw])
					found = 1'b1;
		return found;
	endfunction

	////////////////////////////////////////////////////////////
	// properties
	////////////////////////////////////////////////////////////
	a_unique_notes: assert property (@(posedge CLOCK_25) disable iff (!reset1)
		!has_dup(keys_on, slot_notes))
		else begin
			fail_count++;
			$error("two active slots hold the same note");
		end

	// table only moves the cycle after a strobe
	a_update_after_valid: assert property (@(posedge CLOCK_25) disable iff (!reset1)
		!$stable({keys_on, pitch_val}) |-> $past(valid))
		else begin
			fail_count++;
			$error("keys_on or pitch_val changed without a message");
		end

	a_error_sticky: assert property (@(posedge CLOCK_25)
		$past(reset1) |-> !$fell(note_error))
		else begin
			fail_count++;
			$error("note_error fell outside reset");
		end

endmodule

// attach to every voice table instance
bind channel_state synth_checker #(.voices(voices)) u_checker (
	.CLOCK_25   (CLOCK_25),
	.reset1     (reset1),
	.valid      (msg.valid),
	.keys_on    (keys_on),
	.slot_notes (slot_notes),
	.pitch_val  (pitch_val),
	.note_error (note_error)
);

// ==== verification/synth_tb.sv ====
// testbench for the MIDI front end
// table of serial messages with expected voice table state
module synth_tb import synth_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int voices = default_voices;
	localparam int nsteps = 19;
	localparam int listen = 5;	// selected channel
	localparam int unsigned limit = nsteps * 3 * 10 * clks_per_bit + 2000;

	// one table row, vel_at 3 means no random velocity
	typedef struct packed {
		logic [1:0]  count;	// bytes to send
		logic [7:0]  b0;
		logic [7:0]  b1;
		logic [7:0]  b2;
		logic [1:0]  vel_at;	// byte replaced by random velocity
		logic        bad_stop;	// last byte gets stop bit 0
		logic [1:0]  keys;
		logic [6:0]  note0;
		logic [6:0]  note1;
		logic [13:0] pitch;
		logic        err;
	} step_t;

	logic        CLOCK_25, reset1;
	logic        midi_rxd;
	logic [3:0]  midi_ch;
	logic [1:0]  keys_on;
	logic [13:0] slot_notes;
	bend_t       pitch_val;
	logic        note_error;
	int unsigned cycles = 0;

	////////////////////////////////////////////////////////////
	// stimulus and expected state per step
	////////////////////////////////////////////////////////////
	step_t steps [nsteps] = '{
		'{2'd3, 8'h95, 8'h3C, 8'h00, 2'd2, 1'b0, 2'b01, 7'h3C, 7'h00, 14'h2000, 1'b0},
		'{2'd3, 8'h95, 8'h3C, 8'h00, 2'd2, 1'b0, 2'b01, 7'h3C, 7'h00, 14'h2000, 1'b0},	// held
		'{2'd3, 8'h95, 8'h40, 8'h00, 2'd2, 1'b0, 2'b11, 7'h3C, 7'h40, 14'h2000, 1'b0},
		'{2'd3, 8'h95, 8'h43, 8'h00, 2'd2, 1'b0, 2'b11, 7'h3C, 7'h40, 14'h2000, 1'b0},	// full
		'{2'd3, 8'h95, 8'h3C, 8'h00, 2'd3, 1'b0, 2'b10, 7'h00, 7'h40, 14'h2000, 1'b0},	// vel 0
		'{2'd2, 8'h3E, 8'h00, 8'h00, 2'd1, 1'b0, 2'b11, 7'h3E, 7'h40, 14'h2000, 1'b0},	// running
		'{2'd3, 8'h85, 8'h40, 8'h40, 2'd3, 1'b0, 2'b01, 7'h3E, 7'h00, 14'h2000, 1'b0},
		'{2'd3, 8'h95, 8'h47, 8'h00, 2'd2, 1'b0, 2'b11, 7'h3E, 7'h47, 14'h2000, 1'b0},
		'{2'd3, 8'h3E, 8'hF8, 8'h00, 2'd3, 1'b0, 2'b10, 7'h00, 7'h47, 14'h2000, 1'b0},	// clock byte
		'{2'd3, 8'h48, 8'hFE, 8'h00, 2'd2, 1'b0, 2'b11, 7'h48, 7'h47, 14'h2000, 1'b0},	// sensing
		'{2'd3, 8'h85, 8'h22, 8'h40, 2'd3, 1'b0, 2'b11, 7'h48, 7'h47, 14'h2000, 1'b1},	// stray off
		'{2'd3, 8'hE5, 8'h05, 8'h50, 2'd3, 1'b0, 2'b11, 7'h48, 7'h47, 14'h2805, 1'b1},	// bend
		'{2'd3, 8'h83, 8'h48, 8'h40, 2'd3, 1'b0, 2'b11, 7'h48, 7'h47, 14'h2805, 1'b1},	// other ch
		'{2'd3, 8'hE3, 8'h00, 8'h00, 2'd3, 1'b0, 2'b11, 7'h48, 7'h47, 14'h2805, 1'b1},
		'{2'd2, 8'hC5, 8'h10, 8'h00, 2'd3, 1'b0, 2'b11, 7'h48, 7'h47, 14'h2805, 1'b1},	// program
		'{2'd3, 8'hE5, 8'h7F, 8'h7F, 2'd3, 1'b1, 2'b11, 7'h48, 7'h47, 14'h2805, 1'b1},	// framing
		'{2'd3, 8'hE5, 8'h00, 8'h00, 2'd3, 1'b0, 2'b11, 7'h48, 7'h47, 14'h0000, 1'b1},
		'{2'd3, 8'h85, 8'h48, 8'h00, 2'd3, 1'b0, 2'b10, 7'h00, 7'h47, 14'h0000, 1'b1},
		'{2'd3, 8'h93, 8'h11, 8'h00, 2'd2, 1'b0, 2'b10, 7'h00, 7'h47, 14'h0000, 1'b1}
	};

	clock_gen u_clk (
		.CLOCK_25 (CLOCK_25),
		.reset1   (reset1)
	);

	synthesizer_top #(.voices(voices), .clks_per_bit(clks_per_bit)) dut (
		.CLOCK_25   (CLOCK_25),
		.reset1     (reset1),
		.midi_rxd   (midi_rxd),
		.midi_ch    (midi_ch),
		.keys_on    (keys_on),
		.slot_notes (slot_notes),
		.pitch_val  (pitch_val),
		.note_error (note_error)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////
	// one bit cell, changes 1 ns after the edge
	task automatic drive_bit(input logic b);
		@(posedge CLOCK_25);
		#1;
		midi_rxd = b;
		repeat (clks_per_bit - 1) @(posedge CLOCK_25);
	endtask

	task automatic send_byte(input midi_byte_t b, input logic bad_stop);
		drive_bit(1'b0);	// start
		for (int i = 0; i < 8; i++)
			drive_bit(b[i]);	// lsb first
		drive_bit(!bad_stop);
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// free slots keep stale notes, so only busy ones count
	task automatic verify_step(input int k, input step_t s);
		logic [13:0] mask;
		mask = {{7{s.keys[1]}}, {7{s.keys[0]}}};
		check_value($sformatf("step %0d keys_on", k), 32'(keys_on), 32'(s.keys));
		check_value($sformatf("step %0d slot_notes", k), 32'(slot_notes & mask),
			32'({s.note1, s.note0} & mask));
		check_value($sformatf("step %0d pitch_val", k), 32'(pitch_val), 32'(s.pitch));
		check_value($sformatf("step %0d note_error", k), 32'(note_error), 32'(s.err));
	endtask

	// run limit and voice table assertions
	always @(posedge CLOCK_25) begin
		cycles <= cycles + 1;
		if (dut.u_chan.u_checker.fail_count != 0) begin
			$display("voice table assertion failed at %0t ns", $time);
			$display("TESTBENCH FAILED");
			$fatal(1, "assertion failure");
		end else if (cycles >= limit) begin
			$display("timeout: no result after %0d clock cycles", limit);
			$display("TESTBENCH FAILED");
			$fatal(1, "run limit reached");
		end
	end

	initial begin
		step_t      s;
		midi_byte_t b;
		midi_rxd = 1'b1;	// idle line
		midi_ch  = 4'(listen);
		void'($urandom(65220));
		wait (reset1 == 1'b1);
		repeat (2) @(posedge CLOCK_25);
		@(negedge CLOCK_25);
		check_value("reset keys_on", 32'(keys_on), 32'd0);
		check_value("reset pitch_val", 32'(pitch_val), 32'd8192);
		check_value("reset note_error", 32'(note_error), 32'd0);

		for (int k = 0; k < nsteps; k++) begin
			s = steps[k];
			for (int j = 0; j < int'(s.count); j++) begin
				b = (j == 0) ? s.b0 : (j == 1) ? s.b1 : s.b2;
				if (j == int'(s.vel_at))
					b = 8'(($urandom % 127) + 1);	// velocity 1..127
				send_byte(b, s.bad_stop && (j == int'(s.count) - 1));
			end
			@(posedge CLOCK_25);
			#1;
			midi_rxd = 1'b1;	// back to idle after a bad stop
			repeat (9) @(posedge CLOCK_25);
			@(negedge CLOCK_25);	// outputs settled
			verify_step(k, s);
			repeat (20) @(posedge CLOCK_25);
		end

		if (dut.u_chan.u_checker.fail_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("%0d voice table assertion failures", dut.u_chan.u_checker.fail_count);
			$display("TESTBENCH FAILED");
			$fatal(1, "assertion failure");
		end
	end

endmodule
